/* source/snowbro2_pkg.sv */
/*
 * Snow Bros 2 main-CPU bus glue, shared definitions.
 * Holds the memory map, the sampled 68000 bus, the region selects,
 * the GP9001 command strobes and the cabinet input layout.
 */
`default_nettype none

package snowbro2_pkg;

    // bus widths
    localparam int addr_w = 24;
    localparam int data_w = 16;

    // memory map
    // rom is a flat range, the rest decode on the address fields
    localparam logic [23:0] region_rom_top = 24'h07FFFF;
    // work ram is 0x10xxxx
    localparam logic [7:0]  region_ram     = 8'h10;
    localparam logic [3:0]  region_gcu     = 4'h3;
    localparam logic [3:0]  region_pal     = 4'h4;
    // i/o needs the middle byte at zero too, i.e. 0x700xxx
    localparam logic [3:0]  region_io      = 4'h7;
    // sound chips, upper 16 bits of the byte address
    localparam logic [15:0] page_ym        = 16'h5000;
    localparam logic [15:0] page_oki       = 16'h6000;

    // i/o page offsets
    localparam logic [11:0] io_jmpr    = 12'h000;
    localparam logic [11:0] io_dswa    = 12'h004;
    localparam logic [11:0] io_dswb    = 12'h008;
    localparam logic [11:0] io_in1     = 12'h00C;
    localparam logic [11:0] io_in2     = 12'h010;
    localparam logic [11:0] io_in3     = 12'h014;
    localparam logic [11:0] io_in4     = 12'h018;
    localparam logic [11:0] io_sys     = 12'h01C;
    localparam logic [11:0] io_okibank = 12'h030;

    // gp9001 register offsets, low address nibble
    localparam logic [3:0] gcu_ptr   = 4'h0;
    localparam logic [3:0] gcu_ram_h = 4'h4;
    localparam logic [3:0] gcu_ram_l = 4'h6;
    localparam logic [3:0] gcu_sel   = 4'h8;
    localparam logic [3:0] gcu_reg   = 4'hC;

    // word-address widths of the two rams
    localparam int ram_aw = 15;
    localparam int pal_aw = 11;

    typedef struct packed {
        logic [3:0]  region;
        logic [7:0]  mid;
        logic [11:0] offset;
    } addr_fields_t;

    // same byte address, flat for ranges, split for region compares
    typedef union packed {
        logic [addr_w-1:0] flat;
        addr_fields_t      fields;
    } bus_addr_u;

    typedef struct packed {
        bus_addr_u         addr;
        logic              rw;
        logic              uds_n;
        logic              lds_n;
        logic              as_n;
        logic [data_w-1:0] wdata;
    } cpu_bus_t;

    typedef struct packed {
        logic rom;
        logic ram;
        logic gcu;
        logic pal;
        logic io;
        logic ym;
        logic oki;
    } sel_t;

    typedef struct packed {
        logic select_reg;
        logic write_reg;
        logic write_ram;
        logic read_ram_h;
        logic read_ram_l;
        logic set_ram_ptr;
    } gcu_op_t;

    // all active high on the cabinet side
    typedef struct packed {
        logic [3:0][9:0] joystick;
        logic [3:0]      start;
        logic [3:0]      coin;
        logic            service;
        logic            test;
        logic [7:0]      dip_a;
        logic [7:0]      dip_b;
        logic [7:0]      dip_c;
    } cabinet_t;

    typedef struct packed {
        logic [data_w-1:0] jmpr;
        logic [data_w-1:0] dswa;
        logic [data_w-1:0] dswb;
        logic [data_w-1:0] in1;
        logic [data_w-1:0] in2;
        logic [data_w-1:0] in3;
        logic [data_w-1:0] in4;
        logic [data_w-1:0] sys;
    } io_words_t;

endpackage

`default_nettype wire

/* source/bus_decoder.sv */
/*
 * Bus decoder.
 * Samples the 68000 bus on CLK96 and registers one select per
 * memory region, plus the program ROM word address.
 */
`default_nettype none

module bus_decoder (
    input  wire                         CLK96,
    input  wire                         RESET96,
    input  snowbro2_pkg::cpu_bus_t      cpu_bus,
    output snowbro2_pkg::sel_t          sel,
    output logic [18:0]                 prg_addr
);

    snowbro2_pkg::sel_t hit;
    snowbro2_pkg::bus_addr_u a;

    assign a = cpu_bus.addr;

    // region compares, only meaningful with the address strobe down
    always_comb begin
        hit = '0;
        if (!cpu_bus.as_n) begin
            // program rom, 0x000000-0x07ffff
            hit.rom = a.flat <= snowbro2_pkg::region_rom_top;
            // work ram, upper byte 0x10
            hit.ram = {a.fields.region, a.fields.mid[7:4]} == snowbro2_pkg::region_ram;
            // gp9001 at 0x3xxxxx
            hit.gcu = a.fields.region == snowbro2_pkg::region_gcu;
            // palette at 0x4xxxxx
            hit.pal = a.fields.region == snowbro2_pkg::region_pal;
            // i/o page, 0x700xxx only
            hit.io  = (a.fields.region == snowbro2_pkg::region_io)
                    && (a.fields.mid == 8'h00);
            // sound chips, 256-byte pages
            hit.ym  = a.flat[23:8] == snowbro2_pkg::page_ym;
            hit.oki = a.flat[23:8] == snowbro2_pkg::page_oki;
        end
    end

    // selects drop one cycle after as_n goes back high
    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            sel <= '0;
        end else begin
            sel <= hit;
        end
    end

    // rom word address
    // only follows the bus during an access
    always_ff @(posedge CLK96) begin
        if (!cpu_bus.as_n) begin
            prg_addr <= a.flat[19:1];
        end
    end

endmodule

`default_nettype wire

/* source/cpu_ram16.sv */
/*
 * Two-port 16-bit RAM.
 * Port 0 is the CPU side with byte-lane writes, port 1 is read only.
 * Both read ports are registered, one cycle after the address.
 */
`default_nettype none

module cpu_ram16 #(
    parameter int aw = 10
) (
    input  wire            CLK96,
    input  wire            cs,
    input  wire            rw,
    input  wire            uds_n,
    input  wire            lds_n,
    input  wire  [aw-1:0]  addr0,
    input  wire  [15:0]    wdata,
    input  wire  [aw-1:0]  addr1,
    output logic [15:0]    q0,
    output logic [15:0]    q1
);

    logic [15:0] mem [2**aw];

    always_ff @(posedge CLK96) begin
        // upper lane
        if (cs && !rw && !uds_n) begin
            mem[addr0][15:8] <= wdata[15:8];
        end
        // lower lane
        if (cs && !rw && !lds_n) begin
            mem[addr0][7:0] <= wdata[7:0];
        end
        // old data on a same-cycle write
        q0 <= mem[addr0];
        q1 <= mem[addr1];
    end

endmodule

`default_nettype wire

/* source/io_port_words.sv */
/*
 * Cabinet input words for the I/O page.
 * Turns active-high joysticks, buttons and DIPs into the board's
 * active-low byte layout, each byte doubled across the word.
 */
`default_nettype none

module io_port_words (
    input  snowbro2_pkg::cabinet_t  cabinet,
    output snowbro2_pkg::io_words_t words
);

    logic [7:0] p1_byte;
    logic [7:0] p2_byte;
    logic [7:0] p3_byte;
    logic [7:0] p4_byte;
    logic [7:0] sys_lo;

    // player byte: bit 7 always 0, then buttons and directions
    // order is b3 b2 b1 right left down up, all inverted
    function automatic logic [7:0] player_byte(
        input logic [9:0] joy,
        input logic       has_b3
    );
        logic [7:0] b;
        b[7] = 1'b0;
        // third button only wired on players 3 and 4
        b[6] = has_b3 ? ~joy[6] : 1'b0;
        b[5] = ~joy[5];
        b[4] = ~joy[4];
        b[3] = ~joy[0];
        b[2] = ~joy[1];
        b[1] = ~joy[2];
        b[0] = ~joy[3];
        return b;
    endfunction

    always_comb begin
        p1_byte = player_byte(cabinet.joystick[0], 1'b0);
        p2_byte = player_byte(cabinet.joystick[1], 1'b0);
        p3_byte = player_byte(cabinet.joystick[2], 1'b1);
        p4_byte = player_byte(cabinet.joystick[3], 1'b1);
    end

    // system byte
    // starts, coins, test and service, active low
    assign sys_lo = {
        1'b0,
        ~cabinet.start[1],
        ~cabinet.start[0],
        ~cabinet.coin[1],
        ~cabinet.coin[0],
        ~cabinet.test,
        1'b0,
        ~cabinet.service
    };

    always_comb begin
        words.in1  = {2{p1_byte}};
        words.in2  = {2{p2_byte}};
        words.in3  = {2{p3_byte}};
        words.in4  = {2{p4_byte}};
        // dip c shares the word with the system bits
        words.sys  = {cabinet.dip_c, sys_lo};
        words.dswa = {2{cabinet.dip_a}};
        words.dswb = {2{cabinet.dip_b}};
        // jumper word is dip c
        words.jmpr = {2{cabinet.dip_c}};
    end

endmodule

`default_nettype wire

/* source/gcu_command.sv */
/*
 * GP9001 command strobes and OKI bank latch.
 * A GCU access sets one command level which is held until the
 * GP9001 acknowledges it with no access in progress.
 */
`default_nettype none

module gcu_command (
    input  wire                     CLK96,
    input  wire                     RESET96,
    input  snowbro2_pkg::sel_t      sel,
    input  snowbro2_pkg::cpu_bus_t  cpu_bus,
    input  wire                     gcu_ack,
    output snowbro2_pkg::gcu_op_t   gcu_op,
    output logic                    oki_bank
);

    logic [3:0] nib;
    logic       oki_bank_wr;

    // gp9001 register from the low nibble
    assign nib = cpu_bus.addr.fields.offset[3:0];

    assign oki_bank_wr = sel.io && !cpu_bus.rw
                       && (cpu_bus.addr.fields.offset == snowbro2_pkg::io_okibank);

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            gcu_op <= '0;
        end else if (sel.gcu && cpu_bus.rw) begin
            // reads, vram high or low half
            case (nib)
                snowbro2_pkg::gcu_ram_h: gcu_op.read_ram_h <= 1'b1;
                snowbro2_pkg::gcu_ram_l: gcu_op.read_ram_l <= 1'b1;
                default: ;
            endcase
        end else if (sel.gcu && !cpu_bus.rw) begin
            // writes
            case (nib)
                snowbro2_pkg::gcu_reg:   gcu_op.write_reg   <= 1'b1;
                snowbro2_pkg::gcu_sel:   gcu_op.select_reg  <= 1'b1;
                snowbro2_pkg::gcu_ram_h,
                snowbro2_pkg::gcu_ram_l: gcu_op.write_ram   <= 1'b1;
                snowbro2_pkg::gcu_ptr:   gcu_op.set_ram_ptr <= 1'b1;
                default: ;
            endcase
        end else if (gcu_ack) begin
            // command taken, drop everything
            gcu_op <= '0;
        end
    end

    // sample bank select, data bit 4
    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            oki_bank <= 1'b0;
        end else if (oki_bank_wr) begin
            oki_bank <= cpu_bus.wdata[4];
        end
    end

endmodule

`default_nettype wire

/* source/read_data_mux.sv */
/*
 * CPU read data mux.
 * Registers the word returned to the 68000 from the active select,
 * one cycle after the selects.
 */
`default_nettype none

module read_data_mux (
    input  wire                      CLK96,
    input  wire                      RESET96,
    input  snowbro2_pkg::sel_t       sel,
    input  snowbro2_pkg::cpu_bus_t   cpu_bus,
    input  wire  [15:0]              gcu_data,
    input  wire  [15:0]              prg_data,
    input  wire  [15:0]              ram_q,
    input  wire  [15:0]              pal_q,
    input  snowbro2_pkg::io_words_t  io_words,
    input  wire  [7:0]               oki_dout,
    input  wire  [7:0]               ym_dout,
    output logic [15:0]              rd_data
);

    logic [15:0] io_word;
    logic        rd;

    assign rd = cpu_bus.rw;

    // i/o page offset decode
    always_comb begin
        case (cpu_bus.addr.fields.offset)
            snowbro2_pkg::io_jmpr: io_word = io_words.jmpr;
            snowbro2_pkg::io_dswa: io_word = io_words.dswa;
            snowbro2_pkg::io_dswb: io_word = io_words.dswb;
            snowbro2_pkg::io_in1:  io_word = io_words.in1;
            snowbro2_pkg::io_in2:  io_word = io_words.in2;
            snowbro2_pkg::io_in3:  io_word = io_words.in3;
            snowbro2_pkg::io_in4:  io_word = io_words.in4;
            snowbro2_pkg::io_sys:  io_word = io_words.sys;
            // unmapped offsets read back zero
            default:               io_word = 16'h0000;
        endcase
    end

    // priority order, gcu first
    // rom does not look at rw
    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            rd_data <= 16'h0000;
        end else if (sel.gcu && rd) begin
            rd_data <= gcu_data;
        end else if (sel.rom) begin
            rd_data <= prg_data;
        end else if (sel.ram && rd) begin
            rd_data <= ram_q;
        end else if (sel.pal && rd) begin
            rd_data <= pal_q;
        end else if (sel.io && rd) begin
            rd_data <= io_word;
        end else if (sel.oki && rd) begin
            // 8-bit chips show up on both lanes
            rd_data <= {2{oki_dout}};
        end else if (sel.ym && rd) begin
            rd_data <= {2{ym_dout}};
        end else begin
            rd_data <= 16'h0000;
        end
    end

endmodule

`default_nettype wire

/* source/snowbro2_bus.sv */
/*
 * Snow Bros 2 main-CPU bus glue, top level.
 * Decodes the 68000 bus into ROM, work RAM, palette RAM, GP9001,
 * I/O and sound chip accesses and returns the read word.
 */
`default_nettype none

module snowbro2_bus (
    input  wire                                 CLK96,
    input  wire                                 RESET96,
    input  snowbro2_pkg::cpu_bus_t              cpu_bus,
    output logic [15:0]                         rd_data,

    // program rom
    output logic                                prg_cs,
    output logic [18:0]                         prg_addr,
    input  wire  [15:0]                         prg_data,

    // gp9001
    output snowbro2_pkg::gcu_op_t               gcu_op,
    input  wire                                 gcu_ack,
    input  wire  [15:0]                         gcu_data,

    // palette, video side
    input  wire  [snowbro2_pkg::pal_aw-1:0]     pal_addr,
    output logic [15:0]                         pal_data,

    input  snowbro2_pkg::cabinet_t              cabinet,

    // ym2151 and oki
    output logic                                ym_cs,
    output logic                                oki_cs,
    output logic                                ym_wr_cmd,
    output logic                                oki_we_n,
    input  wire  [7:0]                          ym_dout,
    input  wire  [7:0]                          oki_dout,
    output logic [7:0]                          snd_din,
    output logic                                oki_bank
);

    snowbro2_pkg::sel_t      sel;
    snowbro2_pkg::io_words_t io_words;
    logic [15:0]             ram_q;
    logic [15:0]             pal_q;
    logic [snowbro2_pkg::ram_aw-1:0] ram_addr;
    logic [snowbro2_pkg::pal_aw-1:0] pal_cpu_addr;

    // cpu word addresses into the rams
    assign ram_addr     = cpu_bus.addr.flat[snowbro2_pkg::ram_aw:1];
    assign pal_cpu_addr = cpu_bus.addr.flat[snowbro2_pkg::pal_aw:1];

    bus_decoder bus_decoder_inst (
        .CLK96    (CLK96),
        .RESET96  (RESET96),
        .cpu_bus  (cpu_bus),
        .sel      (sel),
        .prg_addr (prg_addr)
    );

    assign prg_cs = sel.rom;

    // work ram 0x100000-0x10ffff, cpu reads port 0
    cpu_ram16 #(.aw(snowbro2_pkg::ram_aw)) work_ram_inst (
        .CLK96 (CLK96),
        .cs    (sel.ram),
        .rw    (cpu_bus.rw),
        .uds_n (cpu_bus.uds_n),
        .lds_n (cpu_bus.lds_n),
        .addr0 (ram_addr),
        .wdata (cpu_bus.wdata),
        .addr1 (ram_addr),
        .q0    (ram_q),
        .q1    ()
    );

    // palette 0x400000-0x400fff, port 1 feeds video
    cpu_ram16 #(.aw(snowbro2_pkg::pal_aw)) pal_ram_inst (
        .CLK96 (CLK96),
        .cs    (sel.pal),
        .rw    (cpu_bus.rw),
        .uds_n (cpu_bus.uds_n),
        .lds_n (cpu_bus.lds_n),
        .addr0 (pal_cpu_addr),
        .wdata (cpu_bus.wdata),
        .addr1 (pal_addr),
        .q0    (pal_q),
        .q1    (pal_data)
    );

    io_port_words io_port_words_inst (
        .cabinet (cabinet),
        .words   (io_words)
    );

    gcu_command gcu_command_inst (
        .CLK96    (CLK96),
        .RESET96  (RESET96),
        .sel      (sel),
        .cpu_bus  (cpu_bus),
        .gcu_ack  (gcu_ack),
        .gcu_op   (gcu_op),
        .oki_bank (oki_bank)
    );

    read_data_mux read_data_mux_inst (
        .CLK96    (CLK96),
        .RESET96  (RESET96),
        .sel      (sel),
        .cpu_bus  (cpu_bus),
        .gcu_data (gcu_data),
        .prg_data (prg_data),
        .ram_q    (ram_q),
        .pal_q    (pal_q),
        .io_words (io_words),
        .oki_dout (oki_dout),
        .ym_dout  (ym_dout),
        .rd_data  (rd_data)
    );

    // sound chips
    assign ym_cs     = sel.ym;
    assign oki_cs    = sel.oki;
    // offset 0 selects a ym register, offset 2 writes it
    assign ym_wr_cmd = sel.ym && cpu_bus.addr.flat[1];
    assign oki_we_n  = ~(sel.oki && !cpu_bus.rw);
    // both chips sit on the low byte
    assign snd_din   = cpu_bus.wdata[7:0];

endmodule

`default_nettype wire

/* sim/snowbro2_chk.sv */
/*
 * Bound checker for the bus glue.
 * Watches the region selects, the GP9001 strobes and the OKI write enable.
 */
`default_nettype none

module snowbro2_chk (
    input  wire                     CLK96,
    input  wire                     RESET96,
    input  snowbro2_pkg::cpu_bus_t  cpu_bus,
    input  snowbro2_pkg::sel_t      sel,
    input  snowbro2_pkg::gcu_op_t   gcu_op,
    input  wire                     oki_cs,
    input  wire                     oki_we_n
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [6:0] sel_bits;
    logic       gcu_seen;
    logic       oki_bus_write;

    assign sel_bits = sel;

    // 68000 write cycle on the oki page as seen on the raw bus
    assign oki_bus_write = !cpu_bus.as_n && !cpu_bus.rw
                         && (cpu_bus.addr.flat[23:8] == snowbro2_pkg::page_oki);

    // first gcu access since reset
    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            gcu_seen <= 1'b0;
        end else if (sel.gcu) begin
            gcu_seen <= 1'b1;
        end
    end

    // regions never overlap
    one_select: assert property (@(posedge CLK96) disable iff (RESET96) $onehot0(sel_bits))
        else $error("more than one region select set");

    // strobes quiet until the gp9001 is addressed
    quiet_strobes: assert property (@(posedge CLK96) disable iff (RESET96)
        !gcu_seen |-> gcu_op == '0)
        else $error("gcu strobe set before any gcu access");

    // oki write enable needs the chip select and a sampled oki write
    oki_write: assert property (@(posedge CLK96) disable iff (RESET96)
        !oki_we_n |-> oki_cs && $past(oki_bus_write))
        else $error("oki_we_n low without oki_cs or without an oki write on the bus");

endmodule

bind snowbro2_bus snowbro2_chk snowbro2_chk_inst (
    .CLK96    (CLK96),
    .RESET96  (RESET96),
    .cpu_bus  (cpu_bus),
    .sel      (sel),
    .gcu_op   (gcu_op),
    .oki_cs   (oki_cs),
    .oki_we_n (oki_we_n)
);

`default_nettype wire

/* sim/tb_snowbro2.sv */
/*
 * Testbench for the Snow Bros 2 bus glue.
 * Runs directed 68000 accesses against every region and checks the
 * returned words, the GP9001 strobes and the sound chip levels.
 */
`default_nettype none

module tb_snowbro2;

    timeunit 1ns;
    timeprecision 100ps;

    logic                   CLK96;
    logic                   RESET96;
    snowbro2_pkg::cpu_bus_t cpu_bus;
    snowbro2_pkg::gcu_op_t  gcu_op;
    snowbro2_pkg::cabinet_t cabinet;
    logic [15:0]            rd_data;
    logic                   prg_cs;
    logic [18:0]            prg_addr;
    logic [15:0]            prg_data;
    logic                   gcu_ack;
    logic [15:0]            gcu_data;
    logic [10:0]            pal_addr;
    logic [15:0]            pal_data;
    logic                   ym_cs;
    logic                   oki_cs;
    logic                   ym_wr_cmd;
    logic                   oki_we_n;
    logic [7:0]             ym_dout;
    logic [7:0]             oki_dout;
    logic [7:0]             snd_din;
    logic                   oki_bank;

    int                     n_checks;
    int                     n_errors;
    logic [31:0]            lcg_state;
    // outputs captured in the middle of an access
    logic                   snap_prg_cs;
    logic [18:0]            snap_prg_addr;
    logic                   snap_ym_cs;
    logic                   snap_ym_wr_cmd;
    logic                   snap_oki_cs;
    logic                   snap_oki_we_n;
    logic [7:0]             snap_snd_din;
    logic [15:0]            ram_exp [6];
    logic [15:0]            pal_exp [6];

    // rom model, word depends on the whole word address
    function automatic logic [15:0] rom_word(input logic [18:0] wa);
        return {wa[7:0], ~wa[15:8]} ^ {wa[18:16], 13'h1C5A};
    endfunction

    assign prg_data = rom_word(prg_addr);

    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    // active low player byte, button 3 only on players 3 and 4
    function automatic logic [15:0] player_exp(input logic [9:0] joy, input logic has_b3);
        logic [7:0] b;
        b = {1'b0, has_b3 ? ~joy[6] : 1'b0, ~joy[5], ~joy[4],
             ~joy[0], ~joy[1], ~joy[2], ~joy[3]};
        return {b, b};
    endfunction

    snowbro2_bus snowbro2_bus_inst (
        .CLK96     (CLK96),
        .RESET96   (RESET96),
        .cpu_bus   (cpu_bus),
        .rd_data   (rd_data),
        .prg_cs    (prg_cs),
        .prg_addr  (prg_addr),
        .prg_data  (prg_data),
        .gcu_op    (gcu_op),
        .gcu_ack   (gcu_ack),
        .gcu_data  (gcu_data),
        .pal_addr  (pal_addr),
        .pal_data  (pal_data),
        .cabinet   (cabinet),
        .ym_cs     (ym_cs),
        .oki_cs    (oki_cs),
        .ym_wr_cmd (ym_wr_cmd),
        .oki_we_n  (oki_we_n),
        .ym_dout   (ym_dout),
        .oki_dout  (oki_dout),
        .snd_din   (snd_din),
        .oki_bank  (oki_bank)
    );

    initial begin
        CLK96 = 1'b0;
        forever #4 CLK96 = ~CLK96;
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string msg);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL %0t: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    // as_n low for 4 cycles, read word taken after the third edge
    task automatic bus_access(
        input  logic [23:0] addr,
        input  logic        rw,
        input  logic [1:0]  lanes_n,
        input  logic [15:0] wdata,
        output logic [15:0] rdata
    );
        cpu_bus.addr.flat = addr;
        cpu_bus.rw        = rw;
        cpu_bus.uds_n     = lanes_n[1];
        cpu_bus.lds_n     = lanes_n[0];
        cpu_bus.wdata     = wdata;
        cpu_bus.as_n      = 1'b0;
        repeat (3) @(posedge CLK96);
        #1;
        rdata          = rd_data;
        snap_prg_cs    = prg_cs;
        snap_prg_addr  = prg_addr;
        snap_ym_cs     = ym_cs;
        snap_ym_wr_cmd = ym_wr_cmd;
        snap_oki_cs    = oki_cs;
        snap_oki_we_n  = oki_we_n;
        snap_snd_din   = snd_din;
        @(posedge CLK96);
        #1;
        cpu_bus.as_n = 1'b1;
        // idle cycle, selects drop here
        @(posedge CLK96);
        #1;
    endtask

    task automatic bus_write(input logic [23:0] addr, input logic [15:0] data,
                             input logic [1:0] lanes_n);
        logic [15:0] unused;
        bus_access(addr, 1'b0, lanes_n, data, unused);
    endtask

    task automatic bus_read(input logic [23:0] addr, output logic [15:0] data);
        bus_access(addr, 1'b1, 2'b00, 16'h0000, data);
    endtask

    task automatic read_expect(input logic [23:0] addr, input logic [15:0] exp, input string msg);
        logic [15:0] got;
        bus_read(addr, got);
        check_value(32'(got), 32'(exp), msg);
    endtask

    // bit order: select_reg write_reg write_ram read_ram_h read_ram_l set_ram_ptr
    task automatic wait_gcu_op(input logic [5:0] exp, input string what);
        int n;
        n = 0;
        while (gcu_op !== exp && n < 20) begin
            @(posedge CLK96);
            #1;
            n++;
        end
        if (gcu_op !== exp) begin
            n_errors++;
            $display("timeout: GCU strobes for %s never reached %b", what, exp);
        end
    endtask

    task automatic ram_and_palette();
        logic [15:0] w;
        logic [23:0] ra;
        logic [23:0] pa;
        for (int i = 0; i < 6; i++) begin
            ra = 24'h100000 + 24'(i) * 24'h000A42;
            pa = 24'h400000 + 24'(i) * 24'h0001A6;
            w = next_rand();
            bus_write(ra, w, 2'b00);
            ram_exp[i] = w;
            w = next_rand();
            bus_write(pa, w, 2'b00);
            pal_exp[i] = w;
        end
        // single-lane overwrites, upper on ram and lower on palette
        for (int i = 1; i < 6; i += 2) begin
            ra = 24'h100000 + 24'(i) * 24'h000A42;
            pa = 24'h400000 + 24'(i) * 24'h0001A6;
            w = next_rand();
            bus_write(ra, w, 2'b01);
            ram_exp[i] = {w[15:8], ram_exp[i][7:0]};
            bus_write(pa, w, 2'b10);
            pal_exp[i] = {pal_exp[i][15:8], w[7:0]};
        end
        for (int i = 0; i < 6; i++) begin
            ra = 24'h100000 + 24'(i) * 24'h000A42;
            pa = 24'h400000 + 24'(i) * 24'h0001A6;
            read_expect(ra, ram_exp[i], "work ram readback");
            read_expect(pa, pal_exp[i], "palette cpu readback");
            // video port, one cycle after the address
            pal_addr = 11'(i * 211);
            @(posedge CLK96);
            #1;
            check_value(32'(pal_data), 32'(pal_exp[i]), "palette video readback");
        end
    endtask

    task automatic rom_fetch();
        read_expect(24'h001234, rom_word(19'h0091A), "rom read data");
        check_value(32'(snap_prg_cs), 32'd1, "prg_cs during rom access");
        check_value(32'(snap_prg_addr), 32'h0091A, "prg_addr word address");
    endtask

    task automatic io_page();
        logic [15:0] r;
        for (int j = 0; j < 4; j++) begin
            r = next_rand();
            cabinet.joystick[j] = r[9:0];
        end
        r = next_rand();
        cabinet.start   = r[3:0];
        cabinet.coin    = r[7:4];
        cabinet.service = r[8];
        cabinet.test    = r[9];
        r = next_rand();
        cabinet.dip_a = r[7:0];
        cabinet.dip_b = r[15:8];
        r = next_rand();
        cabinet.dip_c = r[7:0];
        read_expect(24'h700000, {2{cabinet.dip_c}}, "io jmpr");
        read_expect(24'h700004, {2{cabinet.dip_a}}, "io dip a");
        read_expect(24'h700008, {2{cabinet.dip_b}}, "io dip b");
        read_expect(24'h70000C, player_exp(cabinet.joystick[0], 1'b0), "io player 1");
        read_expect(24'h700010, player_exp(cabinet.joystick[1], 1'b0), "io player 2");
        read_expect(24'h700014, player_exp(cabinet.joystick[2], 1'b1), "io player 3");
        read_expect(24'h700018, player_exp(cabinet.joystick[3], 1'b1), "io player 4");
        read_expect(24'h70001C, {cabinet.dip_c, 1'b0, ~cabinet.start[1], ~cabinet.start[0],
                    ~cabinet.coin[1], ~cabinet.coin[0], ~cabinet.test, 1'b0,
                    ~cabinet.service}, "io system word");
        read_expect(24'h700030, 16'h0000, "io oki bank offset read");
        read_expect(24'h700020, 16'h0000, "io unmapped offset");
    endtask

    task automatic gcu_command_check(input logic [3:0] nib, input logic rw,
                                     input logic [5:0] exp, input string name);
        logic [15:0] got;
        gcu_data = next_rand();
        if (rw) begin
            bus_read({20'h30000, nib}, got);
            check_value(32'(got), 32'(gcu_data), {name, " read data"});
        end else begin
            bus_write({20'h30000, nib}, next_rand(), 2'b00);
        end
        wait_gcu_op(exp, name);
        check_value(32'(gcu_op), 32'(exp), {name, " strobe set"});
        // no acknowledge yet
        repeat (3) @(posedge CLK96);
        #1;
        check_value(32'(gcu_op), 32'(exp), {name, " strobe held"});
        gcu_ack = 1'b1;
        @(posedge CLK96);
        #1;
        gcu_ack = 1'b0;
        wait_gcu_op(6'b000000, name);
        check_value(32'(gcu_op), 32'd0, {name, " strobe cleared"});
    endtask

    task automatic gcu_strobes();
        gcu_command_check(4'h0, 1'b0, 6'b000001, "gcu pointer write");
        gcu_command_check(4'h8, 1'b0, 6'b100000, "gcu select write");
        gcu_command_check(4'hC, 1'b0, 6'b010000, "gcu register write");
        gcu_command_check(4'h4, 1'b0, 6'b001000, "gcu vram write");
        gcu_command_check(4'h4, 1'b1, 6'b000100, "gcu vram high read");
        gcu_command_check(4'h6, 1'b1, 6'b000010, "gcu vram low read");
    endtask

    task automatic sound_selects();
        logic [15:0] w;
        w = next_rand();
        bus_write(24'h500000, w, 2'b00);
        check_value(32'(snap_ym_cs), 32'd1, "ym_cs at offset 0");
        check_value(32'(snap_ym_wr_cmd), 32'd0, "ym_wr_cmd at offset 0");
        check_value(32'(snap_snd_din), 32'(w[7:0]), "snd_din at ym offset 0");
        w = next_rand();
        bus_write(24'h500002, w, 2'b00);
        check_value(32'(snap_ym_cs), 32'd1, "ym_cs at offset 2");
        check_value(32'(snap_ym_wr_cmd), 32'd1, "ym_wr_cmd at offset 2");
        check_value(32'(snap_snd_din), 32'(w[7:0]), "snd_din at ym offset 2");
        w = next_rand();
        bus_write(24'h600000, w, 2'b00);
        check_value(32'(snap_oki_cs), 32'd1, "oki_cs on write");
        check_value(32'(snap_oki_we_n), 32'd0, "oki_we_n on write");
        check_value(32'(snap_snd_din), 32'(w[7:0]), "snd_din at oki");
        w = next_rand();
        ym_dout  = w[7:0];
        oki_dout = w[15:8];
        read_expect(24'h500000, {2{ym_dout}}, "ym read data");
        read_expect(24'h600000, {2{oki_dout}}, "oki read data");
        check_value(32'(snap_oki_we_n), 32'd1, "oki_we_n on read");
    endtask

    task automatic oki_bank_latch();
        check_value(32'(oki_bank), 32'd0, "oki_bank before any write");
        bus_write(24'h700030, next_rand() | 16'h0010, 2'b00);
        check_value(32'(oki_bank), 32'd1, "oki_bank set by bit 4");
        bus_write(24'h700030, next_rand() & 16'hFFEF, 2'b00);
        check_value(32'(oki_bank), 32'd0, "oki_bank cleared by bit 4");
    endtask

    initial begin
        n_checks      = 0;
        n_errors      = 0;
        lcg_state     = 32'd17;
        RESET96       = 1'b1;
        cpu_bus       = '0;
        cpu_bus.as_n  = 1'b1;
        cpu_bus.rw    = 1'b1;
        cpu_bus.uds_n = 1'b1;
        cpu_bus.lds_n = 1'b1;
        gcu_ack       = 1'b0;
        gcu_data      = 16'h0000;
        pal_addr      = 11'h000;
        cabinet       = '0;
        ym_dout       = 8'h00;
        oki_dout      = 8'h00;
        repeat (2) @(posedge CLK96);
        #1;
        RESET96 = 1'b0;
        check_value(32'(rd_data), 32'd0, "rd_data after reset");
        check_value(32'(prg_cs), 32'd0, "prg_cs after reset");
        check_value(32'(gcu_op), 32'd0, "gcu strobes after reset");
        ram_and_palette();
        rom_fetch();
        io_page();
        gcu_strobes();
        sound_selects();
        oki_bank_latch();
        $display("checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
source/snowbro2_pkg.sv
source/bus_decoder.sv
source/cpu_ram16.sv
source/io_port_words.sv
source/gcu_command.sv
source/read_data_mux.sv
source/snowbro2_bus.sv
sim/snowbro2_chk.sv
sim/tb_snowbro2.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the bus glue testbench.
# The result comes from the pass line in the simulation log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_snowbro2 -f verilog.f \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/Vtb_snowbro2 > sim.log 2>&1
cat sim.log

grep -qx "Testbench passed" sim.log && echo "simulation ok" \
    || { echo "simulation reported failure"; exit 1; }
